// ==== aurora_golden.txt ====
# one command per line, fields in hex
# W valid last word | G cycles | H cycles word | S random_ready | U channel_up | B rx_bytes
# V chan vc_value | T chan st_value | L care lamps | P end pulse | F frames | N cycles | E test
# test 1 frame decode
G 4
W 1 0 EB905716
W 1 0 50312345
W 1 0 500ABCDE
W 1 0 A0D00777
W 1 1 A0300042
P
V 3 00012345
V 0 000ABCDE
T D 00000777
T 3 00000042
V 1 00000000
L 3 3
E 1
# test 2 ignored records, the first word sits in the header slot
G 8
W 1 0 50512345
W 1 0 C0200999
W 1 0 50E11111
W 1 0 A4000555
W 1 1 5FF22222
P
V 5 00000000
V 2 00000000
V 3 00012345
T 3 00000042
E 2
# test 3 timeout, then words without a gap, then a clean frame
G 8
W 1 0 EB905716
W 1 0 50400010
H 2BC C0000000
W 1 0 50400BAD
W 1 1 A0400BAD
G A
V 4 00000010
T 4 00000000
W 1 0 EB905716
W 1 1 50400020
P
V 4 00000020
E 3
# test 4 transmit frames, ready high then random
B EEDDCCBBAA998877665544332211
U 1
S 0
F 1
L C C
S 1
F 2
E 4
# test 5 channel down
U 0
G 28
N 2EE
L F 0
E 5
# test 6 lamps and end pulse
W 1 0 EB905716
W 1 1 A0100001
P
L 3 3
T 1 00000001
G 78
L 3 0
E 6

// ==== verilog.f ====
aurora_app_pkg.sv
rx_frame_parser.sv
channel_table.sv
tx_frame_builder.sv
link_activity_lamps.sv
aurora_app_top.sv
tb_aurora_app.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_aurora_app \
	-f verilog.f -o tb_aurora_app_sim \
	&& out=$(./obj_dir/tb_aurora_app_sim) \
	&& echo "$out" \
	&& echo "$out" | grep -qx "NO ERRORS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== tb_aurora_app.sv ====
// testbench for the backplane link application layer
// commands and expected values come from aurora_golden.txt, read at run time
// checks the channel tables, the tx frame stream, the lamps and the rx end pulse

module tb_aurora_app;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_mhz      = 125;
	localparam int tx_period_us = 2;
	localparam int period_clks  = clk_mhz * tx_period_us;  // 250 cycles
	localparam int reset_clks   = 5;

	logic                                                     clk_sys = 1'b0;
	logic                                                     reset;
	aurora_app_pkg::frame_word_u                              rx_tdata;
	logic                                                     rx_tvalid;
	logic                                                     rx_tlast;
	aurora_app_pkg::frame_word_u                              tx_tdata;
	logic                                                     tx_tvalid;
	logic                                                     tx_tlast;
	logic                                                     tx_tready;
	logic                                                     channel_up;
	aurora_app_pkg::chan_byte_t  [aurora_app_pkg::ch_num-1:0] rx_bytes;
	aurora_app_pkg::chan_value_t [aurora_app_pkg::ch_num-1:0] vc_data;
	aurora_app_pkg::chan_value_t [aurora_app_pkg::ch_num-1:0] st_data;
	logic                                                     rx_end_pulse;
	logic                                                     rx_start_lamp;
	logic                                                     rx_end_lamp;
	logic                                                     tx_start_lamp;
	logic                                                     tx_end_lamp;

	// current golden line
	int                                     fd;
	logic [7:0]                             cmd;
	logic [31:0]                            f1;
	logic [31:0]                            f2;
	logic [31:0]                            f3;
	logic [8*aurora_app_pkg::ch_num-1:0]    bytes_val;
	logic [8*128-1:0]                       line_buf;
	bit                                     stall_random = 1'b0;
	int                                     errors       = 0;
	int                                     test_errors  = 0;
	int                                     checks       = 0;
	int                                     tests_run    = 0;
	int                                     cycle_cnt    = 0;
	int                                     limit_cycles = 0;

	aurora_app_top #(
		.CLK_MHZ      (clk_mhz),
		.TX_PERIOD_US (tx_period_us)
	) dut0 (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.rx_tdata      (rx_tdata),
		.rx_tvalid     (rx_tvalid),
		.rx_tlast      (rx_tlast),
		.tx_tdata      (tx_tdata),
		.tx_tvalid     (tx_tvalid),
		.tx_tlast      (tx_tlast),
		.tx_tready     (tx_tready),
		.channel_up    (channel_up),
		.rx_bytes      (rx_bytes),
		.vc_data       (vc_data),
		.st_data       (st_data),
		.rx_end_pulse  (rx_end_pulse),
		.rx_start_lamp (rx_start_lamp),
		.rx_end_lamp   (rx_end_lamp),
		.tx_start_lamp (tx_start_lamp),
		.tx_end_lamp   (tx_end_lamp)
	);

	always #4 clk_sys = ~clk_sys;                   // 8 ns period

	// cycle limit
	always @(posedge clk_sys)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (limit_cycles > 0 && cycle_cnt >= limit_cycles)
		begin
			$display("run stopped by the cycle limit after %0d cycles", cycle_cnt);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// --------------------------------------------------
	// compare tasks
	task automatic check_chan(input string name, input aurora_app_pkg::chan_value_t got,
		input aurora_app_pkg::chan_value_t exp);
		checks++;
		if (got !== exp)
		begin
			$display("Fail %s got %h expected %h", name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_word(input string name, input aurora_app_pkg::frame_word_u got,
		input aurora_app_pkg::frame_word_u exp);
		checks++;
		if (got !== exp)
		begin
			$display("Fail %s got %h expected %h", name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			$display("Fail %s got %h expected %h", name, got, exp);
			errors++;
			test_errors++;
		end
	endtask

	function automatic string lamp_name(input int idx);
		case (idx)
			0: return "rx_start_lamp";
			1: return "rx_end_lamp";
			2: return "tx_start_lamp";
			default: return "tx_end_lamp";
		endcase
	endfunction

	// --------------------------------------------------
	// golden file reading
	task automatic read_command(output bit ok);
		int code;
		ok   = 1'b0;
		code = $fscanf(fd, " %c", cmd);
		if (code != 1)
			return;
		ok = 1'b1;
		case (cmd)
			"#": code = $fgets(line_buf, fd);             // comment line
			"W": code = $fscanf(fd, " %h %h %h", f1, f2, f3);
			"H", "V", "T", "L": code = $fscanf(fd, " %h %h", f1, f2);
			"G", "S", "U", "N", "F", "E": code = $fscanf(fd, " %h", f1);
			"B": code = $fscanf(fd, " %h", bytes_val);
			default: ;
		endcase
	endtask

	// worst-case cycles a command may take
	function automatic int command_cycles();
		case (cmd)
			"W": return 1;
			"G", "H", "N": return int'(f1);
			"P": return 9;
			"F": return (int'(f1) + 1) * period_clks;
			default: return 0;
		endcase
	endfunction

	// --------------------------------------------------
	// stimulus and response tasks
	task automatic watch_end_pulse();
		for (int i = 1; i <= 9; i++)
		begin
			@(negedge clk_sys);
			check_level("rx_end_pulse", rx_end_pulse, (i >= 3) && (i <= 7));  // 5 cycles high
		end
	endtask

	task automatic capture_frames(input int frames);
		aurora_app_pkg::frame_word_u exp_word;
		logic [31:0]                 rnd;
		int                          k;
		tx_tready = 1'b1;
		while (tx_tvalid)                           // let a running frame drain
			@(negedge clk_sys);
		for (int f = 0; f < frames; f++)
		begin
			k = 0;
			while (k <= aurora_app_pkg::ch_num)
			begin
				rnd       = $urandom;
				tx_tready = stall_random ? rnd[0] : 1'b1;
				if (tx_tvalid && tx_tready)         // transfer at the next rising edge
				begin
					exp_word = aurora_app_pkg::frame_word_u'(aurora_app_pkg::sync_header);
					if (k > 0)
					begin
						exp_word.fc.kind    = aurora_app_pkg::kind_fc;
						exp_word.fc.rsvd    = 4'd0;
						exp_word.fc.index   = 4'(k);
						exp_word.fc.payload = aurora_app_pkg::fc_payload;
						exp_word.fc.data    = rx_bytes[k-1];
					end
					check_word("tx_tdata", tx_tdata, exp_word);
					check_level("tx_tlast", tx_tlast, k == aurora_app_pkg::ch_num);
					k++;
				end
				@(negedge clk_sys);
			end
		end
		tx_tready = 1'b1;
	endtask

	task automatic execute_command();
		logic [3:0] lamps;
		case (cmd)
			"#": ;
			"W":
			begin
				rx_tvalid = f1[0];
				rx_tlast  = f2[0];
				rx_tdata  = aurora_app_pkg::frame_word_u'(f3);
				@(negedge clk_sys);
				rx_tvalid = 1'b0;
				rx_tlast  = 1'b0;
			end
			"G":
			begin
				rx_tvalid = 1'b0;
				repeat (f1) @(negedge clk_sys);
			end
			"H":
			begin
				rx_tvalid = 1'b1;                   // valid stays high, no gap
				rx_tlast  = 1'b0;
				rx_tdata  = aurora_app_pkg::frame_word_u'(f2);
				repeat (f1) @(negedge clk_sys);
				rx_tvalid = 1'b0;
			end
			"S": stall_random = f1[0];
			"U": channel_up = f1[0];
			"B": rx_bytes = bytes_val;
			"V": check_chan($sformatf("vc_data[%0d]", f1), vc_data[f1], f2);
			"T": check_chan($sformatf("st_data[%0d]", f1), st_data[f1], f2);
			"L":
			begin
				lamps = {tx_end_lamp, tx_start_lamp, rx_end_lamp, rx_start_lamp};
				for (int i = 0; i < 4; i++)
					if (f1[i])
						check_level(lamp_name(i), lamps[i], f2[i]);
			end
			"P": watch_end_pulse();
			"F": capture_frames(int'(f1));
			"N":
			begin
				repeat (f1)
				begin
					@(negedge clk_sys);
					check_level("tx_tvalid", tx_tvalid, 1'b0);
				end
			end
			"E":
			begin
				$display("test %0d finished, %0d errors", f1, test_errors);
				tests_run++;
				test_errors = 0;
			end
			default:
			begin
				$display("unknown command %c in the golden file", cmd);
				errors++;
			end
		endcase
	endtask

	// --------------------------------------------------
	// main sequence
	initial
	begin
		bit         ok;
		int         budget;
		logic [3:0] lamp_bits;
		reset      = 1'b1;
		rx_tdata   = '0;
		rx_tvalid  = 1'b0;
		rx_tlast   = 1'b0;
		tx_tready  = 1'b1;
		channel_up = 1'b0;
		rx_bytes   = '0;
		void'($urandom(32'h1584));
		fd = $fopen("aurora_golden.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the golden file aurora_golden.txt");
			errors++;
		end
		else
		begin
			budget = 0;                             // first pass sizes the cycle limit
			read_command(ok);
			while (ok)
			begin
				budget += command_cycles();
				read_command(ok);
			end
			$fclose(fd);
			limit_cycles = 2 * (budget + reset_clks) + 20;
			fd = $fopen("aurora_golden.txt", "r");

			repeat (reset_clks) @(negedge clk_sys);
			reset = 1'b0;
			check_level("tx_tvalid", tx_tvalid, 1'b0);
			check_level("tx_tlast", tx_tlast, 1'b0);
			check_level("rx_end_pulse", rx_end_pulse, 1'b0);
			lamp_bits = {tx_end_lamp, tx_start_lamp, rx_end_lamp, rx_start_lamp};
			for (int i = 0; i < 4; i++)
				check_level(lamp_name(i), lamp_bits[i], 1'b0);
			for (int i = 0; i < aurora_app_pkg::ch_num; i++)
			begin
				check_chan($sformatf("vc_data[%0d]", i), vc_data[i], '0);
				check_chan($sformatf("st_data[%0d]", i), st_data[i], '0);
			end
			$display("test 0 finished, %0d errors", test_errors);
			tests_run++;
			test_errors = 0;

			read_command(ok);
			while (ok)
			begin
				execute_command();
				read_command(ok);
			end
			$fclose(fd);
		end
		$display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== aurora_app_top.sv ====
// top of the backplane link application layer
// joins the rx parser, the channel tables, the tx builder and the lamps
// CLK_MHZ and TX_PERIOD_US are set here and passed down

module aurora_app_top #(
	parameter int CLK_MHZ      = 125,
	parameter int TX_PERIOD_US = 10
)
(
	input  logic                                                     clk_sys,
	input  logic                                                     reset,
	input  aurora_app_pkg::frame_word_u                              rx_tdata,
	input  logic                                                     rx_tvalid,
	input  logic                                                     rx_tlast,
	output aurora_app_pkg::frame_word_u                              tx_tdata,
	output logic                                                     tx_tvalid,
	output logic                                                     tx_tlast,
	input  logic                                                     tx_tready,
	input  logic                                                     channel_up,
	input  aurora_app_pkg::chan_byte_t  [aurora_app_pkg::ch_num-1:0] rx_bytes,
	output aurora_app_pkg::chan_value_t [aurora_app_pkg::ch_num-1:0] vc_data,
	output aurora_app_pkg::chan_value_t [aurora_app_pkg::ch_num-1:0] st_data,
	output logic                                                     rx_end_pulse,
	output logic                                                     rx_start_lamp,
	output logic                                                     rx_end_lamp,
	output logic                                                     tx_start_lamp,
	output logic                                                     tx_end_lamp
);
	logic                        rec_valid;
	aurora_app_pkg::frame_word_u rec_word;
	logic                        frame_start;
	logic                        frame_end;
	logic                        tx_start;
	logic                        tx_end;

	// --------------------------------------------------
	// receive path
	rx_frame_parser u_parser (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.rx_tdata     (rx_tdata),
		.rx_tvalid    (rx_tvalid),
		.rx_tlast     (rx_tlast),
		.rec_valid    (rec_valid),
		.rec_word     (rec_word),
		.frame_start  (frame_start),
		.frame_end    (frame_end),
		.rx_end_pulse (rx_end_pulse)
	);

	channel_table u_table (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.rec_valid (rec_valid),
		.rec_word  (rec_word),
		.vc_data   (vc_data),
		.st_data   (st_data)
	);

	// --------------------------------------------------
	// transmit path and lamps
	tx_frame_builder #(
		.CLK_MHZ      (CLK_MHZ),
		.TX_PERIOD_US (TX_PERIOD_US)
	) u_builder (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.channel_up (channel_up),
		.rx_bytes   (rx_bytes),
		.tx_tready  (tx_tready),
		.tx_tdata   (tx_tdata),
		.tx_tvalid  (tx_tvalid),
		.tx_tlast   (tx_tlast),
		.tx_start   (tx_start),
		.tx_end     (tx_end)
	);

	link_activity_lamps #(
		.CLK_MHZ (CLK_MHZ)
	) u_lamps (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.frame_start   (frame_start),
		.frame_end     (frame_end),
		.tx_start      (tx_start),
		.tx_end        (tx_end),
		.rx_start_lamp (rx_start_lamp),
		.rx_end_lamp   (rx_end_lamp),
		.tx_start_lamp (tx_start_lamp),
		.tx_end_lamp   (tx_end_lamp)
	);

endmodule

// ==== link_activity_lamps.sv ====
// activity lamps for the backplane link
// each event lights its lamp from the next cycle for CLK_MHZ cycles,
// about one microsecond, and a repeated event restarts the count

module link_activity_lamps #(
	parameter int CLK_MHZ = 125
)
(
	input  logic clk_sys,
	input  logic reset,
	input  logic frame_start,
	input  logic frame_end,
	input  logic tx_start,
	input  logic tx_end,
	output logic rx_start_lamp,
	output logic rx_end_lamp,
	output logic tx_start_lamp,
	output logic tx_end_lamp
);
	localparam int cnt_w = $clog2(CLK_MHZ + 1);

	logic [3:0] event_in;
	wire  [3:0] lamp;

	assign event_in = {tx_end, tx_start, frame_end, frame_start};

	// --------------------------------------------------
	// one restartable down-counter per lamp
	for (genvar g = 0; g < 4; g++)
	begin : g_lamp
		logic [cnt_w-1:0] cnt;
		logic             lamp_q;

		always_ff @(posedge clk_sys)
		begin
			if (reset)
			begin
				cnt    <= '0;
				lamp_q <= 1'b0;
			end
			else
			begin
				if (event_in[g])
					cnt <= cnt_w'(CLK_MHZ);
				else if (cnt != '0)
					cnt <= cnt - 1'b1;
				lamp_q <= event_in[g] || (cnt > cnt_w'(1));   // on for CLK_MHZ cycles
			end
		end

		assign lamp[g] = lamp_q;

		a_cnt_bound : assert property (@(posedge clk_sys) disable iff (reset)
			cnt <= cnt_w'(CLK_MHZ));
	end

	assign rx_start_lamp = lamp[0];
	assign rx_end_lamp   = lamp[1];
	assign tx_start_lamp = lamp[2];
	assign tx_end_lamp   = lamp[3];

endmodule

// ==== tx_frame_builder.sv ====
// transmit side of the backplane link
// once per period, while the link is up, sends the sync header followed
// by one flow-control word per channel carrying a snapshot of rx_bytes
// words advance only on accepted transfers, a start during a frame is skipped

module tx_frame_builder #(
	parameter int CLK_MHZ      = 125,
	parameter int TX_PERIOD_US = 10
)
(
	input  logic                                                    clk_sys,
	input  logic                                                    reset,
	input  logic                                                    channel_up,
	input  aurora_app_pkg::chan_byte_t [aurora_app_pkg::ch_num-1:0] rx_bytes,
	input  logic                                                    tx_tready,
	output aurora_app_pkg::frame_word_u                             tx_tdata,
	output logic                                                    tx_tvalid,
	output logic                                                    tx_tlast,
	output logic                                                    tx_start,
	output logic                                                    tx_end
);
	localparam int         period_clks = CLK_MHZ * TX_PERIOD_US;
	localparam int         per_w       = $clog2(period_clks);
	localparam logic [3:0] last_idx    = 4'(aurora_app_pkg::ch_num);

	logic                                                    cu_meta;
	logic                                                    cu_sync;
	logic [per_w-1:0]                                        period_cnt;
	logic [3:0]                                              word_idx;   // word now on the bus
	aurora_app_pkg::chan_byte_t [aurora_app_pkg::ch_num-1:0] snap;
	aurora_app_pkg::frame_word_u                             next_fc;
	logic                                                    accept;

	// --------------------------------------------------
	// channel_up sync and period pacing
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			cu_meta <= 1'b0;
			cu_sync <= 1'b0;
		end
		else
		begin
			cu_meta <= channel_up;
			cu_sync <= cu_meta;
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			period_cnt <= '0;
		else if (period_cnt == per_w'(period_clks - 1))
			period_cnt <= '0;
		else
			period_cnt <= period_cnt + 1'b1;
	end

	assign tx_start = (period_cnt == per_w'(31)) && cu_sync && !tx_tvalid;
	assign accept   = tx_tvalid && tx_tready;
	assign tx_end   = accept && tx_tlast;

	// next flow-control word, byte of channel word_idx
	always_comb
	begin
		next_fc.fc.kind    = aurora_app_pkg::kind_fc;
		next_fc.fc.rsvd    = 4'd0;
		next_fc.fc.index   = word_idx + 4'd1;
		next_fc.fc.payload = aurora_app_pkg::fc_payload;
		next_fc.fc.data    = snap[0];
	end

	// --------------------------------------------------
	// stream control
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			tx_tvalid <= 1'b0;
			tx_tlast  <= 1'b0;
			word_idx  <= 4'd0;
		end
		else if (tx_start)
		begin
			tx_tvalid <= 1'b1;                  // header goes out next cycle
			tx_tlast  <= 1'b0;
			word_idx  <= 4'd0;
		end
		else if (accept)
		begin
			if (tx_tlast)
			begin
				tx_tvalid <= 1'b0;
				tx_tlast  <= 1'b0;
				word_idx  <= 4'd0;
			end
			else
			begin
				word_idx <= word_idx + 4'd1;
				tx_tlast <= (word_idx + 4'd1 == last_idx);
			end
		end
	end

	// word data and snapshot, held while the sink stalls
	always_ff @(posedge clk_sys)
	begin
		if (tx_start)
		begin
			tx_tdata <= aurora_app_pkg::frame_word_u'(aurora_app_pkg::sync_header);
			snap     <= rx_bytes;
		end
		else if (accept && !tx_tlast)
		begin
			tx_tdata <= next_fc;
			snap     <= {aurora_app_pkg::chan_byte_t'(8'h00), snap[aurora_app_pkg::ch_num-1:1]};
		end
	end

	a_hold_on_stall : assert property (@(posedge clk_sys) disable iff (reset)
		tx_tvalid && !tx_tready |=> tx_tvalid && $stable(tx_tdata) && $stable(tx_tlast));

	a_last_has_valid : assert property (@(posedge clk_sys) disable iff (reset)
		tx_tlast |-> tx_tvalid);

endmodule

// ==== channel_table.sv ====
// per-channel tables for the receive side
// VC records update the voltage table, ST records the status table
// anything else, or a channel index out of range, is dropped

module channel_table
(
	input  logic                                                     clk_sys,
	input  logic                                                     reset,
	input  logic                                                     rec_valid,
	input  aurora_app_pkg::frame_word_u                              rec_word,
	output aurora_app_pkg::chan_value_t [aurora_app_pkg::ch_num-1:0] vc_data,
	output aurora_app_pkg::chan_value_t [aurora_app_pkg::ch_num-1:0] st_data
);
	logic                        chan_ok;
	logic                        vc_we;
	logic                        st_we;
	aurora_app_pkg::chan_value_t new_value;

	assign chan_ok   = rec_word.rec.chan < 8'(aurora_app_pkg::ch_num);
	assign vc_we     = rec_valid && chan_ok && (rec_word.rec.kind == aurora_app_pkg::kind_vc);
	assign st_we     = rec_valid && chan_ok && (rec_word.rec.kind == aurora_app_pkg::kind_st);
	assign new_value = {12'd0, rec_word.rec.value};

	// --------------------------------------------------
	// table write, one entry per record
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			vc_data <= '0;
			st_data <= '0;
		end
		else
		begin
			for (int i = 0; i < aurora_app_pkg::ch_num; i++)
			begin
				if (vc_we && rec_word.rec.chan == 8'(i))
					vc_data[i] <= new_value;
				if (st_we && rec_word.rec.chan == 8'(i))
					st_data[i] <= new_value;
			end
		end
	end

	// flow-control words coming back on rx must not touch either table
	a_fc_no_write : assert property (@(posedge clk_sys) disable iff (reset)
		rec_valid && rec_word.rec.kind == aurora_app_pkg::kind_fc
		|=> $stable(vc_data) && $stable(st_data));

endmodule

// ==== rx_frame_parser.sv ====
// receive side of the backplane link
// registers the incoming word stream twice, finds frame boundaries,
// drops the sync header and hands each body word on as a record
// a frame without last is abandoned after the timeout

module rx_frame_parser
(
	input  logic                        clk_sys,
	input  logic                        reset,
	input  aurora_app_pkg::frame_word_u rx_tdata,
	input  logic                        rx_tvalid,
	input  logic                        rx_tlast,
	output logic                        rec_valid,
	output aurora_app_pkg::frame_word_u rec_word,
	output logic                        frame_start,
	output logic                        frame_end,
	output logic                        rx_end_pulse
);
	localparam int to_w  = $clog2(aurora_app_pkg::rx_timeout_clks + 1);
	localparam int ext_w = $clog2(aurora_app_pkg::end_extend_clks + 1);

	logic                        valid_d1;
	logic                        valid_d2;
	logic                        last_d1;
	logic                        last_d2;
	aurora_app_pkg::frame_word_u data_d1;
	aurora_app_pkg::frame_word_u data_d2;
	logic                        receiving;
	logic                        header_pend;   // next word in stage 2 is the header
	logic [to_w-1:0]             timeout_cnt;
	logic                        timed_out;
	logic                        open_start;
	logic                        word_live;
	logic [ext_w-1:0]            end_cnt;

	// --------------------------------------------------
	// input pipeline
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			valid_d1 <= 1'b0;
			valid_d2 <= 1'b0;
		end
		else
		begin
			valid_d1 <= rx_tvalid;
			valid_d2 <= valid_d1;
		end
		data_d1 <= rx_tdata;
		data_d2 <= data_d1;
		last_d1 <= rx_tlast;
		last_d2 <= last_d1;
	end

	// valid rising after a gap opens a frame, only from idle
	assign open_start = !receiving && valid_d1 && !valid_d2;
	assign timed_out  = receiving && (timeout_cnt >= to_w'(aurora_app_pkg::rx_timeout_clks));
	assign word_live  = receiving && valid_d2;

	// --------------------------------------------------
	// frame state
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			receiving   <= 1'b0;
			header_pend <= 1'b0;
		end
		else
		begin
			if (timed_out)
				receiving <= 1'b0;
			else if (open_start)
				receiving <= 1'b1;
			else if (word_live && last_d2)
				receiving <= 1'b0;

			if (open_start)
				header_pend <= 1'b1;
			else if (word_live)
				header_pend <= 1'b0;            // header consumed
		end
	end

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			timeout_cnt <= '0;
		else if (open_start)
			timeout_cnt <= '0;
		else if (receiving)
			timeout_cnt <= timeout_cnt + 1'b1;
	end

	// --------------------------------------------------
	// records and frame events
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			rec_valid   <= 1'b0;
			frame_start <= 1'b0;
			frame_end   <= 1'b0;
		end
		else
		begin
			rec_valid   <= word_live && !header_pend;
			frame_start <= open_start;
			frame_end   <= word_live && last_d2;
		end
		rec_word <= data_d2;
	end

	// stretched end pulse, restarts on every frame end
	always_ff @(posedge clk_sys)
	begin
		if (reset)
			end_cnt <= '0;
		else if (frame_end)
			end_cnt <= ext_w'(aurora_app_pkg::end_extend_clks);
		else if (end_cnt != '0)
			end_cnt <= end_cnt - 1'b1;
	end

	assign rx_end_pulse = (end_cnt != '0);

	// a frame cannot open and close on the same edge
	a_start_end_apart : assert property (@(posedge clk_sys) disable iff (reset)
		!(frame_start && frame_end));

endmodule

// ==== aurora_app_pkg.sv ====
// shared types and constants for the backplane link application layer
// rtl and testbench refer to these by scoped names
// one frame word is read either as a channel record or as a flow-control word

package aurora_app_pkg;

	localparam int ch_num = 14;                 // optical channels on the board

	// --------------------------------------------------
	// word kinds, top nibble of every body word
	typedef enum logic [3:0]
	{
		kind_vc = 4'h5,
		kind_st = 4'hA,
		kind_fc = 4'hC
	} word_kind_e;

	localparam logic [31:0] sync_header = 32'hEB90_5716;
	localparam logic [11:0] fc_payload  = 12'h78D;

	localparam int rx_timeout_clks = 640;       // about 5 us at 125 MHz
	localparam int end_extend_clks = 5;

	typedef logic [31:0] chan_value_t;          // 20-bit value, zero-extended
	typedef logic [7:0]  chan_byte_t;

	// --------------------------------------------------
	// the two readings of a frame word
	typedef struct packed
	{
		logic [3:0]  kind;
		logic [7:0]  chan;
		logic [19:0] value;
	} rec_view_t;

	typedef struct packed
	{
		logic [3:0]  kind;
		logic [3:0]  rsvd;                      // always zero on tx
		logic [3:0]  index;                     // word number inside the frame
		logic [11:0] payload;
		logic [7:0]  data;
	} fc_view_t;

	typedef union packed
	{
		rec_view_t rec;
		fc_view_t  fc;
	} frame_word_u;

endpackage
